/* Makefile */
# Verilator build and run of the scan-out engine testbench

SRCS := $(shell grep -v '^+' all.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_video: $(SRCS) all.f
	verilator --binary --timing --assert --top-module tb_video -f all.f -o Vtb_video

run: obj_dir/Vtb_video
	obj_dir/Vtb_video | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
timing_pkg.sv
pixel_pkg.sv
raster_if.sv
frame_sync.sv
raster_timing.sv
line_buffer.sv
pixel_pipe.sv
video_top.sv
tb_video.sv

/* frame_sync.sv */
/*
 * Frame resync
 * Synchronises the external flyback and holds the timing generator off
 * until flyback ends, then acknowledges the toggle request
 */

`timescale 1ns/1ps

module frame_sync (
   input  logic pclk,
   input  logic reset,
   input  logic i_sync_flyback,   // Async flyback from the video controller
   input  logic i_sync_req,       // Toggle request, async
   output logic o_sync_ack,       // Toggles once per completed resync
   output logic o_vid_enable,     // Low holds the timing generator
   output logic o_flyback_fall    // One cycle at end of flyback
);

   typedef enum logic [1:0] {
      S_IDLE,   // Running, waiting for a request
      S_HOLD,   // Timing held, minimum hold time
      S_WAIT    // Waiting for flyback to end
   } state_t;

   logic [1:0] req_sync;   // Request synchroniser
   logic [2:0] fb_sync;    // Two sync flops plus previous value
   logic       pending;
   state_t     state;
   logic [1:0] hold_ctr;

   always_ff @(posedge pclk) begin
      req_sync <= {req_sync[0], i_sync_req};
      fb_sync  <= {fb_sync[1:0], i_sync_flyback};
   end

   assign pending        = req_sync[1] != o_sync_ack;   // Request and ack differ
   assign o_flyback_fall = !fb_sync[1] && fb_sync[2];

   //////////////////////////////////////////////////////////////////////
   // Resync FSM

   always_ff @(posedge pclk) begin
      if (reset) begin
         state        <= S_IDLE;
         hold_ctr     <= 2'd0;
         o_vid_enable <= 1'b1;   // Free-running out of reset
         o_sync_ack   <= 1'b0;
      end else begin
         case (state)
            S_IDLE: if (pending) begin
               state        <= S_HOLD;
               o_vid_enable <= 1'b0;   // Timing gen reloads config
               hold_ctr     <= 2'd2;
            end
            S_HOLD: if (hold_ctr == 2'd0) state <= S_WAIT;
                    else hold_ctr <= hold_ctr - 2'd1;
            S_WAIT: if (o_flyback_fall) begin   // May miss one, next frame then
               state        <= S_IDLE;
               o_vid_enable <= 1'b1;
               o_sync_ack   <= ~o_sync_ack;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Ack moves with the release, only after the drop cycle and the full hold
   a_ack_on_release: assert property (@(posedge pclk) disable iff (reset)
      (o_sync_ack != $past(o_sync_ack)) |->
         (o_vid_enable && !$past(o_vid_enable) && !$past(o_vid_enable, 2)
          && !$past(o_vid_enable, 3) && !$past(o_vid_enable, 4)))
      else $error("sync ack toggled without a full hold of the timing gen");

endmodule

/* line_buffer.sv */
/*
 * Line buffer
 * Two line halves written by DMA beats and read by raster position,
 * even display lines from half 0 and odd lines from half 1
 */

`timescale 1ns/1ps

module line_buffer #(
   parameter int WORDS_MAX = 256   // Words per half
) (
   input  logic              pclk,
   input  logic              reset,
   input  logic              i_flyback_fall,   // Frame start, rewind to half 0
   input  logic              i_dma_strobe,     // One word per strobe
   input  pixel_pkg::word_t  i_dma_data,
   input  logic [7:0]        i_words_m1,       // Words per line minus 1
   input  pixel_pkg::bpp_t   i_bpp,
   raster_if.sink            rif,
   output pixel_pkg::word_t  o_word,           // Word under dispx, 1 cycle later
   output logic [4:0]        o_xidx            // dispx low bits, aligned with o_word
);

   localparam int AW = $clog2(WORDS_MAX);

   pixel_pkg::word_t mem [0:2*WORDS_MAX-1];
   logic             wr_half;
   logic [AW-1:0]    wr_word;
   logic [AW-1:0]    rd_word;

   //////////////////////////////////////////////////////////////////////
   // DMA write side

   always_ff @(posedge pclk) begin
      if (reset || i_flyback_fall) begin
         wr_half <= 1'b0;
         wr_word <= '0;
      end else if (i_dma_strobe) begin
         if (wr_word == AW'(i_words_m1)) begin   // Line done, swap halves
            wr_half <= ~wr_half;
            wr_word <= '0;
         end else begin
            wr_word <= wr_word + AW'(1);
         end
      end
   end

   always_ff @(posedge pclk) begin
      if (i_dma_strobe) mem[{wr_half, wr_word}] <= i_dma_data;
   end

   //////////////////////////////////////////////////////////////////////
   // Raster read side

   always_comb begin
      case (i_bpp)
         pixel_pkg::BPP1: rd_word = AW'(rif.dispx >> 5);
         pixel_pkg::BPP2: rd_word = AW'(rif.dispx >> 4);
         default:         rd_word = AW'(rif.dispx >> 3);   // 4bpp and reserved
      endcase
   end

   always_ff @(posedge pclk) begin
      o_word <= mem[{rif.line_odd, rd_word}];
      o_xidx <= rif.dispx[4:0];
   end

   // Pointer wraps at the programmed line length
   a_wr_ptr_bound: assert property (@(posedge pclk) disable iff (reset)
      wr_word <= AW'(i_words_m1))
      else $error("DMA write pointer beyond line length");

endmodule

/* pixel_pipe.sv */
/*
 * Pixel pipeline
 * Picks the pixel out of the line word, looks it up in the palette and
 * expands it to 8 bits per channel, keeping the syncs aligned
 */

`timescale 1ns/1ps

module pixel_pipe (
   input  logic                pclk,
   input  logic                reset,
   input  pixel_pkg::word_t    i_word,      // From the line buffer
   input  logic [4:0]          i_xidx,      // Pixel position within word
   input  pixel_pkg::bpp_t     i_bpp,
   input  pixel_pkg::palette_t i_palette,
   raster_if.sink              rif,
   output logic [7:0]          o_r,
   output logic [7:0]          o_g,
   output logic [7:0]          o_b,
   output logic                o_hsync,
   output logic                o_vsync,
   output logic                o_de,
   output logic                o_blank
);

   logic [3:0]        pix_idx;   // Logical colour
   pixel_pkg::rgb12_t pix_rgb;
   logic [2:0]        hs_d;      // Sync flag delay lines
   logic [2:0]        vs_d;
   logic [2:0]        de_d;

   //////////////////////////////////////////////////////////////////////
   // Field select and palette

   always_comb begin
      case (i_bpp)
         pixel_pkg::BPP1: pix_idx = {3'b000, i_word[i_xidx]};
         pixel_pkg::BPP2: pix_idx = {2'b00, i_word[{i_xidx[3:0], 1'b0} +: 2]};
         default:         pix_idx = i_word[{i_xidx[2:0], 2'b00} +: 4];
      endcase
   end

   always_ff @(posedge pclk) begin
      pix_rgb <= i_palette[pix_idx];   // Stage 2 of 3
   end

   //////////////////////////////////////////////////////////////////////
   // Expansion to 8 bits

   // Low nibble filled with the channel MSB
   always_ff @(posedge pclk) begin
      o_r <= {pix_rgb.r, {4{pix_rgb.r[3]}}};
      o_g <= {pix_rgb.g, {4{pix_rgb.g[3]}}};
      o_b <= {pix_rgb.b, {4{pix_rgb.b[3]}}};
   end

   //////////////////////////////////////////////////////////////////////
   // Sync delay

   // Three stages to match buffer read, lookup and expansion
   always_ff @(posedge pclk) begin
      if (reset) begin
         hs_d <= 3'b000;
         vs_d <= 3'b000;
         de_d <= 3'b000;
      end else begin
         hs_d <= {hs_d[1:0], rif.i_hsync};
         vs_d <= {vs_d[1:0], rif.i_vsync};
         de_d <= {de_d[1:0], rif.i_de};
      end
   end

   assign o_hsync = hs_d[2];
   assign o_vsync = vs_d[2];
   assign o_de    = de_d[2];
   assign o_blank = ~de_d[2];   // Blank outside the active area

endmodule

/* pixel_pkg.sv */
/*
 * Pixel format definitions
 * Colour depth, line buffer word and palette types for the scan-out
 * datapath
 */

package pixel_pkg;

   //////////////////////////////////////////////////////////////////////
   // Colour depth

   // Value 3 is reserved, treated like 4bpp by the datapath
   typedef enum logic [1:0] {
      BPP1 = 2'd0,   // 32 pixels per word
      BPP2 = 2'd1,   // 16 pixels per word
      BPP4 = 2'd2    // 8 pixels per word
   } bpp_t;

   // DMA beat and line buffer entry, pixels packed LSB first
   typedef logic [31:0] word_t;

   //////////////////////////////////////////////////////////////////////
   // Palette

   // 4 bits per channel, red lowest
   typedef struct packed {
      logic [3:0] b;   // Bits 11:8
      logic [3:0] g;   // Bits 7:4
      logic [3:0] r;   // Bits 3:0
   } rgb12_t;

   // 16 logical colours, entry 0 in the lowest 12 bits
   typedef rgb12_t [15:0] palette_t;

endpackage

/* raster_if.sv */
/*
 * Raster bundle
 * Current scan position and sync flags, all in the pclk domain,
 * from the timing generator to the line buffer and pixel pipe
 */

`timescale 1ns/1ps

interface raster_if;

   logic             i_de;       // Display enable, active area only
   logic             i_hsync;    // High during horizontal sync
   logic             i_vsync;    // High during vertical sync
   timing_pkg::ctr_t dispx;      // Pixel index within the active line
   logic             line_odd;   // Bit 0 of active line index

   // Timing generator side
   modport src (
      output i_de, i_hsync, i_vsync,
      output dispx, line_odd
   );

   // Line buffer and pixel pipe side
   modport sink (
      input i_de, i_hsync, i_vsync,
      input dispx, line_odd
   );

endinterface

/* raster_timing.sv */
/*
 * Raster timing generator
 * Horizontal and vertical counters with sync at coordinate 0, display
 * enable over the active area and the pixel and line position
 */

`timescale 1ns/1ps

module raster_timing (
   input  logic                  pclk,
   input  logic                  reset,
   input  logic                  i_vid_enable,   // Low reloads config and parks
   input  timing_pkg::axis_cfg_t i_h_cfg,
   input  timing_pkg::axis_cfg_t i_v_cfg,
   raster_if.src                 rif
);

   // Boundaries, latched while held
   timing_pkg::ctr_t h_sync_off;     // First px after hsync
   timing_pkg::ctr_t h_disp_start;   // First active px
   timing_pkg::ctr_t h_disp_end;     // First px after active
   timing_pkg::ctr_t h_last;         // Last px of the line
   timing_pkg::ctr_t v_sync_off;
   timing_pkg::ctr_t v_disp_start;
   timing_pkg::ctr_t v_disp_end;
   timing_pkg::ctr_t v_last;

   timing_pkg::ctr_t px;
   timing_pkg::ctr_t py;
   timing_pkg::ctr_t py_next;
   logic             line_odd_q;   // Active line index, bit 0
   logic             h_on;
   logic             v_on;

   //////////////////////////////////////////////////////////////////////
   // Configuration latch and counters

   assign py_next = (py == v_last) ? '0 : py + timing_pkg::ctr_t'(1);

   always_ff @(posedge pclk) begin
      if (reset || !i_vid_enable) begin
         // Running sums of the fields give the boundaries
         h_sync_off   <= i_h_cfg.sync_width;
         h_disp_start <= i_h_cfg.sync_width + i_h_cfg.back_porch;
         h_disp_end   <= i_h_cfg.sync_width + i_h_cfg.back_porch + i_h_cfg.active;
         h_last       <= i_h_cfg.sync_width + i_h_cfg.back_porch + i_h_cfg.active
                         + i_h_cfg.front_porch - timing_pkg::ctr_t'(1);
         v_sync_off   <= i_v_cfg.sync_width;
         v_disp_start <= i_v_cfg.sync_width + i_v_cfg.back_porch;
         v_disp_end   <= i_v_cfg.sync_width + i_v_cfg.back_porch + i_v_cfg.active;
         v_last       <= i_v_cfg.sync_width + i_v_cfg.back_porch + i_v_cfg.active
                         + i_v_cfg.front_porch - timing_pkg::ctr_t'(1);

         // Park on the line before the first display line
         px         <= '0;
         py         <= i_v_cfg.sync_width + i_v_cfg.back_porch - timing_pkg::ctr_t'(1);
         line_odd_q <= 1'b1;
      end else if (px == h_last) begin
         px <= '0;   // New line
         py <= py_next;
         // Even on the first display line, then alternating
         line_odd_q <= (py_next == v_disp_start) ? 1'b0 : ~line_odd_q;
      end else begin
         px <= px + timing_pkg::ctr_t'(1);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Flags and position

   assign h_on = (px >= h_disp_start) && (px < h_disp_end);
   assign v_on = (py >= v_disp_start) && (py < v_disp_end);   // Display line

   assign rif.i_hsync  = px < h_sync_off;
   assign rif.i_vsync  = py < v_sync_off;
   assign rif.i_de     = h_on && v_on;
   assign rif.dispx    = px - h_disp_start;   // Only meaningful with de
   assign rif.line_odd = line_odd_q;

   // Active area must sit clear of the sync pulse
   a_de_outside_hsync: assert property (@(posedge pclk) disable iff (reset)
      !(rif.i_de && rif.i_hsync))
      else $error("de high during hsync");

endmodule

/* tb_video.sv */
/*
 * Testbench for the video scan-out engine
 * Small raster with random line words and palette, checked by
 * concurrent assertions against a reference copy of buffer and palette
 */

`timescale 1ns/1ps

module tb_video;

   localparam int H_SYNC   = 4;
   localparam int H_BP     = 6;
   localparam int H_ACTIVE = 32;
   localparam int H_FP     = 4;
   localparam int V_SYNC   = 2;
   localparam int V_BP     = 2;
   localparam int V_ACTIVE = 4;
   localparam int V_FP     = 2;
   localparam int H_TOTAL  = H_SYNC + H_BP + H_ACTIVE + H_FP;   // 46 cycles
   localparam int V_TOTAL  = V_SYNC + V_BP + V_ACTIVE + V_FP;   // 10 lines
   localparam int LIMIT    = 4 * H_TOTAL * V_TOTAL;             // Cycles per test

   logic            pclk = 1'b0;
   logic            reset;
   logic [7:0]      words_m1;
   pixel_pkg::bpp_t bpp;
   logic [191:0]    palette_bits;   // Entry 0 in the low 12 bits
   logic            dma_strobe;
   logic [31:0]     dma_data;
   logic            flyback;
   logic            sync_req;
   logic            sync_ack;
   logic [7:0]      r, g, b;
   logic            hsync, vsync, de, blank;

   logic [31:0] buf_model [2][4];   // Half, word
   logic [11:0] pal_model [16];
   int          bits_per_px;
   logic        armed;              // Raster released with known data
   logic        ack_want;
   logic        hs_q;
   logic        vs_q;
   int          hs_len, hs_gap, vs_len, pix_k, line_idx;
   int          errors, err_mark, tests_run, tests_failed, test_no;

   always #10 pclk = ~pclk;

   video_top #(.WORDS_MAX(256)) dut (
      .pclk(pclk), .reset(reset),
      .i_h_sync_width(11'(H_SYNC)), .i_h_back_porch(11'(H_BP)),
      .i_h_active(11'(H_ACTIVE)), .i_h_front_porch(11'(H_FP)),
      .i_v_sync_width(11'(V_SYNC)), .i_v_back_porch(11'(V_BP)),
      .i_v_active(11'(V_ACTIVE)), .i_v_front_porch(11'(V_FP)),
      .i_words_m1(words_m1), .i_bpp(bpp), .i_palette(palette_bits),
      .i_dma_strobe(dma_strobe), .i_dma_data(dma_data),
      .i_sync_flyback(flyback), .i_sync_req(sync_req), .o_sync_ack(sync_ack),
      .o_r(r), .o_g(g), .o_b(b), .o_hsync(hsync), .o_vsync(vsync),
      .o_de(de), .o_blank(blank)
   );

   //////////////////////////////////////////////////////////////////////
   // Reference model and reporting

   // Pixel k of display line n, LSB first, MSB-replicated expansion
   function automatic logic [7:0] expected_channel(input int line, input int k, input int ch);
      int          ppw;
      logic [1:0]  wi;
      logic [31:0] w;
      logic [3:0]  fld;
      logic [3:0]  c;
      ppw = 32 / bits_per_px;
      wi  = 2'(k / ppw);
      w   = buf_model[line[0]][wi] >> ((k % ppw) * bits_per_px);
      fld = 4'(w & ((32'd1 << bits_per_px) - 32'd1));
      case (ch)
         0:       c = pal_model[fld][3:0];    // Red
         1:       c = pal_model[fld][7:4];    // Green
         default: c = pal_model[fld][11:8];   // Blue
      endcase
      return {c, {4{c[3]}}};
   endfunction

   task automatic count_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
      errors++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", sig, got, exp);
   endtask

   task automatic flag_failure(input string what);
      errors++;
      $display("error: %s", what);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Output monitors

   // Run lengths only count runs that began while armed
   always @(posedge pclk) begin
      hs_q  <= hsync;
      vs_q  <= vsync;
      pix_k <= de ? pix_k + 1 : 0;   // Index of current active pixel
      if (!armed) begin
         hs_len   <= 0;
         hs_gap   <= 0;
         vs_len   <= 0;
         line_idx <= 0;
      end else begin
         if (hsync && !hs_q) hs_len <= 1;
         else if (hsync && hs_len != 0) hs_len <= hs_len + 1;
         else hs_len <= 0;
         if (hsync && !hs_q) hs_gap <= 1;   // Cycles since last hsync rise
         else if (hs_gap != 0) hs_gap <= hs_gap + 1;
         if (vsync && !vs_q) vs_len <= 1;
         else if (vsync && vs_len != 0) vs_len <= vs_len + 1;
         else vs_len <= 0;
         if (vsync) line_idx <= 0;
         else if (!de && pix_k != 0) line_idx <= line_idx + 1;   // End of a display line
      end
   end

   a_reset_state: assert property (@(posedge pclk)
      $fell(reset) |-> (!sync_ack && !de && blank))
      else flag_failure("outputs not idle right after reset");

   a_resync_ack: assert property (@(posedge pclk) disable iff (reset)
      $fell(flyback) |-> ##8 (sync_ack == ack_want))
      else flag_failure("sync ack did not toggle within 8 cycles of flyback end");

   a_blank: assert property (@(posedge pclk) disable iff (reset) blank == !de)
      else count_mismatch("o_blank", 32'($sampled(blank)), 32'(!$sampled(de)));

   a_hsync_width: assert property (@(posedge pclk) disable iff (reset || !armed)
      ($fell(hsync) && hs_len != 0) |-> hs_len == H_SYNC)
      else count_mismatch("o_hsync width", $sampled(hs_len), H_SYNC);

   a_line_period: assert property (@(posedge pclk) disable iff (reset || !armed)
      ($rose(hsync) && hs_gap != 0) |-> hs_gap == H_TOTAL)
      else count_mismatch("o_hsync period", $sampled(hs_gap), H_TOTAL);

   a_de_width: assert property (@(posedge pclk) disable iff (reset || !armed)
      $fell(de) |-> pix_k == H_ACTIVE)
      else count_mismatch("o_de width", $sampled(pix_k), H_ACTIVE);

   a_vsync_width: assert property (@(posedge pclk) disable iff (reset || !armed)
      ($fell(vsync) && vs_len != 0) |-> vs_len == V_SYNC * H_TOTAL)
      else count_mismatch("o_vsync width", $sampled(vs_len), V_SYNC * H_TOTAL);

   a_frame_lines: assert property (@(posedge pclk) disable iff (reset || !armed)
      $rose(vsync) |-> line_idx == V_ACTIVE)
      else count_mismatch("display lines", $sampled(line_idx), V_ACTIVE);

   a_pix_r: assert property (@(posedge pclk) disable iff (reset || !armed)
      de |-> r == expected_channel(line_idx, pix_k, 0))
      else count_mismatch("o_r", $sampled(r),
                          expected_channel($sampled(line_idx), $sampled(pix_k), 0));

   a_pix_g: assert property (@(posedge pclk) disable iff (reset || !armed)
      de |-> g == expected_channel(line_idx, pix_k, 1))
      else count_mismatch("o_g", $sampled(g),
                          expected_channel($sampled(line_idx), $sampled(pix_k), 1));

   a_pix_b: assert property (@(posedge pclk) disable iff (reset || !armed)
      de |-> b == expected_channel(line_idx, pix_k, 2))
      else count_mismatch("o_b", $sampled(b),
                          expected_channel($sampled(line_idx), $sampled(pix_k), 2));

   //////////////////////////////////////////////////////////////////////
   // Stimulus tasks

   // Both halves, 4 words each, back-to-back strobes
   task automatic fill_line_buffer();
      logic [3:0] n;
      for (n = 4'd0; n < 4'd8; n++) begin
         buf_model[n[2]][n[1:0]] = $urandom;
         dma_data   = buf_model[n[2]][n[1:0]];
         dma_strobe = 1'b1;
         @(negedge pclk);
      end
      dma_strobe = 1'b0;
   endtask

   task automatic pick_palette();
      logic [4:0] i;
      for (i = 5'd0; i < 5'd16; i++) begin
         pal_model[i[3:0]] = 12'($urandom);
         palette_bits = {pal_model[i[3:0]], palette_bits[191:12]};   // Shift down
      end
   endtask

   // Flyback held over the hold time, then released
   task automatic resync_frame();
      ack_want = ~sync_ack;
      sync_req = ~sync_req;
      flyback  = 1'b1;
      repeat (10) @(negedge pclk);
      flyback = 1'b0;
      wait (sync_ack == ack_want);
      @(negedge pclk);
      armed = 1'b1;
   endtask

   task automatic start_test();
      test_no++;
      err_mark = errors;
   endtask

   task automatic close_test(input string name);
      tests_run++;
      if (errors != err_mark) begin
         tests_failed++;
         $display("test %0d %s: FAIL, %0d errors", test_no, name, errors - err_mark);
      end else begin
         $display("test %0d %s: pass", test_no, name);
      end
   endtask

   task automatic run_depth(input pixel_pkg::bpp_t mode, input int bits, input string name);
      start_test();
      armed       = 1'b0;
      bpp         = mode;
      bits_per_px = bits;
      fill_line_buffer();
      pick_palette();
      resync_frame();
      repeat (2) @(posedge vsync);   // Partial frame, then a full one
      @(negedge pclk);
      close_test(name);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      void'($urandom(35484));
      reset        = 1'b1;
      words_m1     = 8'd3;
      bpp          = pixel_pkg::BPP1;
      bits_per_px  = 1;
      palette_bits = '0;
      dma_strobe   = 1'b0;
      dma_data     = '0;
      flyback      = 1'b0;
      sync_req     = 1'b0;
      armed        = 1'b0;
      ack_want     = 1'b0;
      errors       = 0;
      err_mark     = 0;
      tests_run    = 0;
      tests_failed = 0;
      test_no      = 0;
      repeat (5) @(negedge pclk);

      start_test();
      reset = 1'b0;
      repeat (4) @(negedge pclk);
      close_test("reset state");

      start_test();
      fill_line_buffer();
      pick_palette();
      resync_frame();
      close_test("resync handshake");

      start_test();
      repeat (2 * V_TOTAL) @(posedge hsync);
      @(negedge pclk);
      close_test("horizontal timing");

      start_test();
      repeat (3) @(posedge vsync);
      @(negedge pclk);
      close_test("vertical timing");

      run_depth(pixel_pkg::BPP1, 1, "pixel data 1bpp");
      run_depth(pixel_pkg::BPP2, 2, "pixel data 2bpp");
      run_depth(pixel_pkg::BPP4, 4, "pixel data 4bpp");

      $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Watchdog, restarted by each new test
   initial begin : watchdog
      int seen;
      int cnt;
      seen = 0;
      cnt  = 0;
      while (cnt <= LIMIT) begin
         @(posedge pclk);
         if (test_no != seen) begin
            seen = test_no;
            cnt  = 0;
         end
         cnt++;
      end
      $display("timeout: test %0d still running after %0d cycles", test_no, LIMIT);
      $display("Simulation failed");
      $finish;
   end

endmodule

/* timing_pkg.sv */
/*
 * Raster timing definitions
 * Coordinate width and per-axis timing configuration shared by the
 * timing generator, line buffer and top level
 */

package timing_pkg;

   //////////////////////////////////////////////////////////////////////
   // Coordinate width

   // Enough for 2048 pixels or lines per axis
   localparam int CTR_W = 11;

   // Raster coordinate, also used for all timing values
   typedef logic [CTR_W-1:0] ctr_t;

   //////////////////////////////////////////////////////////////////////
   // Per-axis configuration

   /* Sync sits at coordinate 0, then back porch, active area and
    * front porch follow in that order.  First field lands in the MSBs.
    */
   typedef struct packed {
      ctr_t sync_width;    // Sync pulse length
      ctr_t back_porch;    // Sync end to first active
      ctr_t active;        // Visible pixels or lines
      ctr_t front_porch;   // Last active to next sync
   } axis_cfg_t;           // 44 bits

   // Total period of an axis is the sum of all four fields
   // Values are counts, not end positions

endpackage

/* video_top.sv */
/*
 * Video scan-out engine
 * Resync handshake, raster timing, double line buffer and pixel
 * pipeline, all in the pclk domain
 */

`timescale 1ns/1ps

module video_top #(
   parameter int WORDS_MAX = 256   // Line buffer words per half
) (
   input  logic                pclk,
   input  logic                reset,
   input  timing_pkg::ctr_t    i_h_sync_width,
   input  timing_pkg::ctr_t    i_h_back_porch,
   input  timing_pkg::ctr_t    i_h_active,
   input  timing_pkg::ctr_t    i_h_front_porch,
   input  timing_pkg::ctr_t    i_v_sync_width,
   input  timing_pkg::ctr_t    i_v_back_porch,
   input  timing_pkg::ctr_t    i_v_active,
   input  timing_pkg::ctr_t    i_v_front_porch,
   input  logic [7:0]          i_words_m1,
   input  pixel_pkg::bpp_t     i_bpp,
   input  pixel_pkg::palette_t i_palette,
   input  logic                i_dma_strobe,
   input  pixel_pkg::word_t    i_dma_data,
   input  logic                i_sync_flyback,
   input  logic                i_sync_req,
   output logic                o_sync_ack,
   output logic [7:0]          o_r,
   output logic [7:0]          o_g,
   output logic [7:0]          o_b,
   output logic                o_hsync,
   output logic                o_vsync,
   output logic                o_de,
   output logic                o_blank
);

   timing_pkg::axis_cfg_t h_cfg;
   timing_pkg::axis_cfg_t v_cfg;
   logic                  vid_enable;
   logic                  flyback_fall;
   pixel_pkg::word_t      lb_word;
   logic [4:0]            lb_xidx;

   raster_if rif ();   // Timing gen to buffer and pipe

   assign h_cfg = '{sync_width: i_h_sync_width, back_porch: i_h_back_porch,
                    active: i_h_active, front_porch: i_h_front_porch};
   assign v_cfg = '{sync_width: i_v_sync_width, back_porch: i_v_back_porch,
                    active: i_v_active, front_porch: i_v_front_porch};

   frame_sync u_frame_sync (
      .pclk(pclk), .reset(reset),
      .i_sync_flyback(i_sync_flyback), .i_sync_req(i_sync_req),
      .o_sync_ack(o_sync_ack), .o_vid_enable(vid_enable),
      .o_flyback_fall(flyback_fall)
   );

   raster_timing u_raster_timing (
      .pclk(pclk), .reset(reset), .i_vid_enable(vid_enable),
      .i_h_cfg(h_cfg), .i_v_cfg(v_cfg), .rif(rif)
   );

   line_buffer #(.WORDS_MAX(WORDS_MAX)) u_line_buffer (
      .pclk(pclk), .reset(reset), .i_flyback_fall(flyback_fall),
      .i_dma_strobe(i_dma_strobe), .i_dma_data(i_dma_data),
      .i_words_m1(i_words_m1), .i_bpp(i_bpp), .rif(rif),
      .o_word(lb_word), .o_xidx(lb_xidx)
   );

   pixel_pipe u_pixel_pipe (
      .pclk(pclk), .reset(reset), .i_word(lb_word), .i_xidx(lb_xidx),
      .i_bpp(i_bpp), .i_palette(i_palette), .rif(rif),
      .o_r(o_r), .o_g(o_g), .o_b(o_b), .o_hsync(o_hsync),
      .o_vsync(o_vsync), .o_de(o_de), .o_blank(o_blank)
   );

endmodule
